/* compile.f */
common/lc3b_types.sv
control/control_rom.sv
datapath/regfile.sv
datapath/alu.sv
datapath/lc3b_datapath.sv
source/lc3b_cpu.sv
verification/lc3b_cpu_tb.sv

/* verification/lc3b_cpu_tb.sv */
module lc3b_cpu_tb
    import lc3b_types::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic     clk = 1'b0;
    logic     rst_n;
    lc3b_word imem_addr, imem_rdata;
    lc3b_word dmem_addr, dmem_wdata, dmem_rdata;
    logic     dmem_write;

    lc3b_word    imem [256];
    lc3b_word    dmem [128];
    logic [31:0] expected_stores [$]; // {addr, data}
    logic [31:0] next_store;
    lc3b_word    last_fetch;
    logic        was_out_of_reset;
    int          value_errors;
    int          other_errors;
    int          cycles;

    lc3b_cpu dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_write (dmem_write)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // combinational read ports, word addressed
    assign imem_rdata = imem[imem_addr[8:1]];
    assign dmem_rdata = dmem[dmem_addr[7:1]];

    always @(posedge clk) begin
        if (dmem_write) begin
            dmem[dmem_addr[7:1]] <= dmem_wdata;
        end
    end

    // instruction formats with two register fields and a 6-bit low field
    function automatic lc3b_word fmt_rr6(input lc3b_opcode op, input logic [2:0] a,
                                         input logic [2:0] b, input logic [5:0] low);
        return {op, a, b, low};
    endfunction

    // br, lea: a 3-bit field and a 9-bit pc offset
    function automatic lc3b_word fmt_r9(input lc3b_opcode op, input logic [2:0] a,
                                        input logic [8:0] off9);
        return {op, a, off9};
    endfunction

    task automatic place(input lc3b_word addr, input lc3b_word instr);
        imem[addr[8:1]] = instr;
    endtask

    task automatic expect_store(input lc3b_word addr, input lc3b_word data);
        expected_stores.push_back({addr, data});
    endtask

    task automatic report_mismatch(input string what, input lc3b_word got,
                                   input lc3b_word expected);
        $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, expected);
        value_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        other_errors++;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst_n || !was_out_of_reset) begin
            assert (!dmem_write) else report_mismatch("dmem_write in reset", 16'(dmem_write), 0);
            assert (imem_addr == reset_pc) else report_mismatch("reset pc", imem_addr, reset_pc);
        end
        if (rst_n) begin
            if (dmem_write) begin
                if (expected_stores.size() == 0) begin
                    report_problem($sformatf("unexpected store of %h to address %h at %0t ns",
                                             dmem_wdata, dmem_addr, $time));
                end else begin
                    next_store = expected_stores.pop_front();
                    assert (dmem_addr == next_store[31:16])
                        else report_mismatch("store address", dmem_addr, next_store[31:16]);
                    assert (dmem_wdata == next_store[15:0])
                        else report_mismatch("store data", dmem_wdata, next_store[15:0]);
                end
            end
            // jmp r6 at 0x46 redirects after the squashed fetch of 0x48
            if (last_fetch == 16'h0048) begin
                assert (imem_addr == 16'h0050)
                    else report_mismatch("jmp fetch", imem_addr, 16'h0050);
            end
            assert (imem_addr != 16'h0034 && imem_addr != 16'h003c && imem_addr != 16'h004a)
                else report_mismatch("fetch past taken redirect", imem_addr, 16'hxxxx);
            last_fetch = imem_addr;
        end
        was_out_of_reset = rst_n;
    end

    initial begin
        rst_n            = 1'b0;
        last_fetch       = 16'hffff;
        was_out_of_reset = 1'b0;
        value_errors     = 0;
        other_errors     = 0;
        cycles           = 0;

        for (int i = 0; i < 256; i++) begin
            imem[i] = 16'h0000; // nop padding
        end
        for (int i = 0; i < 128; i++) begin
            dmem[i] = 16'hc000 | lc3b_word'(i * 2); // word at byte address a holds c000 | a
        end

        place(16'h00, fmt_rr6(op_add, 3'd1, 3'd0, 6'b1_00111));     // r1 = 7
        place(16'h02, fmt_rr6(op_add, 3'd2, 3'd1, {1'b1, 5'h1d}));  // r2 = r1 - 3
        place(16'h04, fmt_rr6(op_add, 3'd3, 3'd1, 6'd2));           // r3 = r1 + r2
        place(16'h06, fmt_rr6(op_str, 3'd3, 3'd0, 6'd0));
        place(16'h08, fmt_rr6(op_and, 3'd4, 3'd3, {1'b1, 5'h1e}));  // r4 = r3 & -2
        place(16'h0a, fmt_rr6(op_and, 3'd4, 3'd4, 6'd1));           // r4 = r4 & r1
        place(16'h0c, fmt_rr6(op_str, 3'd4, 3'd0, 6'd1));
        place(16'h0e, fmt_rr6(op_not, 3'd5, 3'd4, 6'h3f));
        place(16'h10, fmt_rr6(op_str, 3'd5, 3'd0, 6'd2));
        place(16'h12, fmt_rr6(op_shf, 3'd6, 3'd3, 6'b00_0100));     // sll 4
        place(16'h14, fmt_rr6(op_str, 3'd6, 3'd0, 6'd3));
        place(16'h16, fmt_rr6(op_not, 3'd6, 3'd6, 6'h3f));
        place(16'h18, fmt_rr6(op_shf, 3'd7, 3'd6, 6'b11_0100));     // sra 4
        place(16'h1a, fmt_rr6(op_str, 3'd7, 3'd0, 6'd4));
        place(16'h1c, fmt_rr6(op_shf, 3'd7, 3'd6, 6'b01_0100));     // srl 4
        place(16'h1e, fmt_rr6(op_str, 3'd7, 3'd0, 6'd5));
        place(16'h20, fmt_r9(op_lea, 3'd5, 9'd15));                 // r5 = 0x40
        place(16'h22, fmt_rr6(op_str, 3'd5, 3'd0, 6'd6));
        place(16'h24, fmt_rr6(op_ldr, 3'd1, 3'd5, 6'd3));           // load from 0x46, cc n
        place(16'h26, fmt_rr6(op_str, 3'd1, 3'd5, 6'h3c));          // offset -4
        place(16'h28, fmt_r9(op_br, 3'b011, 9'd2));                 // brzp, not taken
        place(16'h2a, fmt_rr6(op_str, 3'd3, 3'd0, 6'd7));
        place(16'h2c, fmt_rr6(op_add, 3'd2, 3'd0, 6'b1_00000));     // r2 = 0, cc z
        place(16'h2e, fmt_rr6(op_str, 3'd2, 3'd0, 6'd8));
        place(16'h30, fmt_r9(op_br, 3'b010, 9'd2));                 // brz to 0x36
        place(16'h32, fmt_rr6(op_str, 3'd1, 3'd0, 6'd9));
        place(16'h34, fmt_rr6(op_str, 3'd1, 3'd0, 6'd10));
        place(16'h36, fmt_rr6(op_str, 3'd4, 3'd0, 6'd11));
        place(16'h38, {op_jsr, 1'b1, 11'd4});                       // jsr to 0x42
        place(16'h3a, fmt_rr6(op_str, 3'd1, 3'd0, 6'd12));
        place(16'h42, fmt_rr6(op_str, 3'd7, 3'd0, 6'd13));
        place(16'h44, fmt_r9(op_lea, 3'd6, 9'd5));                  // r6 = 0x50
        place(16'h46, fmt_rr6(op_jmp, 3'd0, 3'd6, 6'd0));
        place(16'h48, fmt_rr6(op_str, 3'd1, 3'd0, 6'd14));
        place(16'h50, fmt_rr6(op_str, 3'd6, 3'd0, 6'd15));
        place(16'h52, fmt_rr6(op_ldb, 3'd2, 3'd5, 6'd0));           // not decoded
        place(16'h54, {op_trap, 4'h0, 8'h25});                      // not decoded
        place(16'h56, fmt_rr6(op_str, 3'd2, 3'd0, 6'd16));
        place(16'h58, fmt_rr6(op_str, 3'd7, 3'd0, 6'd17));
        place(16'h5a, fmt_r9(op_br, 3'b111, 9'h1ff));               // spin here

        expect_store(16'h0000, 16'h000b);
        expect_store(16'h0002, 16'h0002);
        expect_store(16'h0004, 16'hfffd);
        expect_store(16'h0006, 16'h00b0);
        expect_store(16'h0008, 16'hfff4);
        expect_store(16'h000a, 16'h0ff4);
        expect_store(16'h000c, 16'h0040);
        expect_store(16'h0038, 16'hc046);
        expect_store(16'h000e, 16'h000b); // not-taken marker
        expect_store(16'h0010, 16'h0000);
        expect_store(16'h0016, 16'h0002); // branch target marker
        expect_store(16'h001a, 16'h003a); // link of jsr
        expect_store(16'h001e, 16'h0050);
        expect_store(16'h0020, 16'h0000);
        expect_store(16'h0022, 16'h003a);

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        while (expected_stores.size() != 0 && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        if (expected_stores.size() != 0) begin
            report_problem($sformatf("timed out after %0d cycles with %0d stores still missing",
                                     cycles, expected_stores.size()));
        end

        repeat (4) @(posedge clk); // catch any stray store
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : lc3b_cpu_tb

/* source/lc3b_cpu.sv */
module lc3b_cpu
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     rst_n,
    output lc3b_word imem_addr,
    input  lc3b_word imem_rdata,
    output lc3b_word dmem_addr,
    output lc3b_word dmem_wdata,
    input  lc3b_word dmem_rdata,
    output logic     dmem_write
);

    lc3b_word       ir;
    logic           conditional_branch, sr2_from_dest, cc_load;
    logic           dmem_write_en, dest_r7, regfile_load;
    lc3b_pc_sel     pc_sel;
    lc3b_offset_sel offset_sel;
    lc3b_alu_b_sel  alu_b_sel;
    lc3b_alu_op     alu_op;
    lc3b_wb_sel     wb_sel;

    control_rom control_rom0 (
        .ir                 (ir),
        .conditional_branch (conditional_branch),
        .pc_sel             (pc_sel),
        .offset_sel         (offset_sel),
        .sr2_from_dest      (sr2_from_dest),
        .alu_b_sel          (alu_b_sel),
        .alu_op             (alu_op),
        .cc_load            (cc_load),
        .dmem_write_en      (dmem_write_en),
        .wb_sel             (wb_sel),
        .dest_r7            (dest_r7),
        .regfile_load       (regfile_load)
    );

    lc3b_datapath datapath0 (
        .clk                (clk),
        .rst_n              (rst_n),
        .imem_addr          (imem_addr),
        .imem_rdata         (imem_rdata),
        .dmem_addr          (dmem_addr),
        .dmem_wdata         (dmem_wdata),
        .dmem_rdata         (dmem_rdata),
        .dmem_write         (dmem_write),
        .ir                 (ir),
        .conditional_branch (conditional_branch),
        .pc_sel             (pc_sel),
        .offset_sel         (offset_sel),
        .sr2_from_dest      (sr2_from_dest),
        .alu_b_sel          (alu_b_sel),
        .alu_op             (alu_op),
        .cc_load            (cc_load),
        .dmem_write_en      (dmem_write_en),
        .wb_sel             (wb_sel),
        .dest_r7            (dest_r7),
        .regfile_load       (regfile_load)
    );

endmodule : lc3b_cpu

/* datapath/lc3b_datapath.sv */
module lc3b_datapath
    import lc3b_types::*;
(
    input  logic           clk,
    input  logic           rst_n,

    output lc3b_word       imem_addr,
    input  lc3b_word       imem_rdata,
    output lc3b_word       dmem_addr,
    output lc3b_word       dmem_wdata,
    input  lc3b_word       dmem_rdata,
    output logic           dmem_write,

    output lc3b_word       ir,

    input  logic           conditional_branch,
    input  lc3b_pc_sel     pc_sel,
    input  lc3b_offset_sel offset_sel,
    input  logic           sr2_from_dest,
    input  lc3b_alu_b_sel  alu_b_sel,
    input  lc3b_alu_op     alu_op,
    input  logic           cc_load,
    input  logic           dmem_write_en,
    input  lc3b_wb_sel     wb_sel,
    input  logic           dest_r7,
    input  logic           regfile_load
);

    lc3b_word pc, pc_next, ir_dx;
    logic     branch_taken;
    lc3b_reg  sr2, dest_dx;
    lc3b_word sr1_data, sr2_data, alu_b, alu_result, target;
    lc3b_word imm5_sext, imm4, offset6_w, offset9_w, offset11_w;

    lc3b_word   alu_mw, target_mw, link_mw, store_mw;
    lc3b_reg    dest_mw;
    logic       regfile_load_mw, cc_load_mw, dmem_write_mw;
    lc3b_wb_sel wb_sel_mw;
    lc3b_word   wb_data;
    lc3b_nzp    nzp, nzp_next;

    assign imem_addr = pc;
    assign ir        = ir_dx;

    assign imm5_sext  = {{11{ir_dx[4]}}, ir_dx[4:0]};
    assign imm4       = {12'b0, ir_dx[3:0]};
    assign offset6_w  = {{9{ir_dx[5]}}, ir_dx[5:0], 1'b0};
    assign offset9_w  = {{6{ir_dx[8]}}, ir_dx[8:0], 1'b0};
    assign offset11_w = {{4{ir_dx[10]}}, ir_dx[10:0], 1'b0};

    assign sr2     = sr2_from_dest ? ir_dx[11:9] : ir_dx[2:0];
    assign dest_dx = dest_r7 ? r7 : ir_dx[11:9];

    regfile regfile0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (regfile_load_mw),
        .dest     (dest_mw),
        .data     (wb_data),
        .sr1      (ir_dx[8:6]),
        .sr2      (sr2),
        .sr1_data (sr1_data),
        .sr2_data (sr2_data)
    );

    always_comb begin
        case (alu_b_sel)
            alu_b_imm5:      alu_b = imm5_sext;
            alu_b_imm4:      alu_b = imm4;
            alu_b_offset6_w: alu_b = offset6_w;
            default:         alu_b = sr2_data;
        endcase
    end

    alu alu0 (
        .op     (alu_op),
        .a      (sr1_data),
        .b      (alu_b),
        .result (alu_result)
    );

    // no stalls, so pc already holds pc + 2 of the dx instruction
    assign target = pc + ((offset_sel == offset_sel_11) ? offset11_w : offset9_w);

    assign branch_taken = (pc_sel != pc_sel_plus2) &&
                          (!conditional_branch || |(ir_dx[11:9] & nzp));

    always_comb begin
        pc_next = pc + 16'd2;
        if (branch_taken) begin
            pc_next = (pc_sel == pc_sel_base) ? alu_result : target;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc    <= reset_pc;
            ir_dx <= '0;
        end else begin
            pc    <= pc_next;
            ir_dx <= branch_taken ? '0 : imem_rdata; // squash fall-through
        end
    end

    // mw pipeline register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regfile_load_mw <= 1'b0;
            cc_load_mw      <= 1'b0;
            dmem_write_mw   <= 1'b0;
            wb_sel_mw       <= wb_sel_alu;
        end else begin
            regfile_load_mw <= regfile_load;
            cc_load_mw      <= cc_load;
            dmem_write_mw   <= dmem_write_en;
            wb_sel_mw       <= wb_sel;
        end
    end

    always_ff @(posedge clk) begin
        alu_mw    <= alu_result;
        target_mw <= target;
        link_mw   <= pc;
        store_mw  <= sr2_data;
        dest_mw   <= dest_dx;
    end

    assign dmem_addr  = alu_mw;
    assign dmem_wdata = store_mw;
    assign dmem_write = dmem_write_mw;

    always_comb begin
        case (wb_sel_mw)
            wb_sel_mdr:    wb_data = dmem_rdata;
            wb_sel_pc:     wb_data = link_mw;
            wb_sel_target: wb_data = target_mw;
            default:       wb_data = alu_mw;
        endcase
    end

    assign nzp_next = wb_data[15]       ? 3'b100 :
                      (wb_data == '0)   ? 3'b010 : 3'b001;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            nzp <= 3'b010; // z after reset
        end else if (cc_load_mw) begin
            nzp <= nzp_next;
        end
    end

endmodule : lc3b_datapath

/* datapath/alu.sv */
module alu
    import lc3b_types::*;
(
    input  lc3b_alu_op op,
    input  lc3b_word   a,
    input  lc3b_word   b,
    output lc3b_word   result
);

    logic [3:0] shamt;

    assign shamt = b[3:0]; // only imm4 matters for shifts

    always_comb begin
        case (op)
            alu_op_add:  result = a + b;
            alu_op_and:  result = a & b;
            alu_op_not:  result = ~a;
            alu_op_sll:  result = a << shamt;
            alu_op_srl:  result = a >> shamt;
            alu_op_sra:  result = lc3b_word'($signed(a) >>> shamt); // keeps sign
            alu_op_pass: result = a;
            default:     result = a;
        endcase
    end

endmodule : alu

/* datapath/regfile.sv */
module regfile
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  lc3b_reg  dest,
    input  lc3b_word data,
    input  lc3b_reg  sr1,
    input  lc3b_reg  sr2,
    output lc3b_word sr1_data,
    output lc3b_word sr2_data
);

    lc3b_word regs [8];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= data;
        end
    end

    // write-through so the dx read sees this cycle's writeback
    assign sr1_data = (load && (dest == sr1)) ? data : regs[sr1];
    assign sr2_data = (load && (dest == sr2)) ? data : regs[sr2];

endmodule : regfile

/* control/control_rom.sv */
module control_rom
    import lc3b_types::*;
(
    input  lc3b_word       ir,

    output logic           conditional_branch,
    output lc3b_pc_sel     pc_sel,
    output lc3b_offset_sel offset_sel,
    output logic           sr2_from_dest,
    output lc3b_alu_b_sel  alu_b_sel,
    output lc3b_alu_op     alu_op,
    output logic           cc_load,
    output logic           dmem_write_en,
    output lc3b_wb_sel     wb_sel,
    output logic           dest_r7,
    output logic           regfile_load
);

    lc3b_opcode opcode;

    assign opcode = lc3b_opcode'(ir[15:12]);

    always_comb begin
        // all-zero word acts as nop
        conditional_branch = 1'b0;
        pc_sel             = pc_sel_plus2;
        offset_sel         = offset_sel_9;
        sr2_from_dest      = 1'b0;
        alu_b_sel          = alu_b_sr2;
        alu_op             = alu_op_add;
        cc_load            = 1'b0;
        dmem_write_en      = 1'b0;
        wb_sel             = wb_sel_alu;
        dest_r7            = 1'b0;
        regfile_load       = 1'b0;

        case (opcode)
            op_add, op_and: begin
                alu_op       = (opcode == op_add) ? alu_op_add : alu_op_and;
                alu_b_sel    = ir[5] ? alu_b_imm5 : alu_b_sr2; // imm5 form
                cc_load      = 1'b1;
                regfile_load = 1'b1;
            end

            op_not: begin
                alu_op       = alu_op_not;
                cc_load      = 1'b1;
                regfile_load = 1'b1;
            end

            op_shf: begin
                alu_b_sel = alu_b_imm4;
                if (!ir[4]) begin
                    alu_op = alu_op_sll;
                end else if (!ir[5]) begin
                    alu_op = alu_op_srl;
                end else begin
                    alu_op = alu_op_sra;
                end
                cc_load      = 1'b1;
                regfile_load = 1'b1;
            end

            op_ldr: begin
                alu_b_sel    = alu_b_offset6_w; // base + 2*offset6
                alu_op       = alu_op_add;
                wb_sel       = wb_sel_mdr;
                cc_load      = 1'b1;
                regfile_load = 1'b1;
            end

            op_str: begin
                alu_b_sel     = alu_b_offset6_w;
                alu_op        = alu_op_add;
                sr2_from_dest = 1'b1; // store data comes from ir[11:9]
                dmem_write_en = 1'b1;
            end

            op_br: begin
                conditional_branch = 1'b1;
                pc_sel             = pc_sel_target;
                offset_sel         = offset_sel_9;
            end

            op_jmp: begin
                alu_op = alu_op_pass; // base register straight through
                pc_sel = pc_sel_base;
            end

            op_jsr: begin
                if (ir[11]) begin
                    pc_sel     = pc_sel_target; // jsr
                    offset_sel = offset_sel_11;
                end else begin
                    pc_sel = pc_sel_base; // jsrr
                    alu_op = alu_op_pass;
                end
                wb_sel       = wb_sel_pc;
                dest_r7      = 1'b1;
                regfile_load = 1'b1;
            end

            op_lea: begin
                offset_sel   = offset_sel_9;
                wb_sel       = wb_sel_target; // cc left alone
                regfile_load = 1'b1;
            end

            default: begin
                // byte ops, trap, rti, ldi, sti keep the nop word
            end
        endcase
    end

endmodule : control_rom

/* common/lc3b_types.sv */
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    // encodings follow the ISA, bits 15:12 of the instruction
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef logic [2:0] lc3b_alu_op;

    localparam lc3b_alu_op alu_op_add  = 3'd0;
    localparam lc3b_alu_op alu_op_and  = 3'd1;
    localparam lc3b_alu_op alu_op_not  = 3'd2;
    localparam lc3b_alu_op alu_op_pass = 3'd3; // result = a
    localparam lc3b_alu_op alu_op_sll  = 3'd4;
    localparam lc3b_alu_op alu_op_srl  = 3'd5;
    localparam lc3b_alu_op alu_op_sra  = 3'd6;

    // next pc source on a taken redirect
    typedef logic [1:0] lc3b_pc_sel;

    localparam lc3b_pc_sel pc_sel_plus2  = 2'd0;
    localparam lc3b_pc_sel pc_sel_base   = 2'd1; // from alu, jmp / jsrr
    localparam lc3b_pc_sel pc_sel_target = 2'd2; // from pc adder

    typedef logic [1:0] lc3b_alu_b_sel;

    localparam lc3b_alu_b_sel alu_b_sr2       = 2'd0;
    localparam lc3b_alu_b_sel alu_b_imm5      = 2'd1;
    localparam lc3b_alu_b_sel alu_b_imm4      = 2'd2;
    localparam lc3b_alu_b_sel alu_b_offset6_w = 2'd3; // word offset, shifted left

    typedef logic lc3b_offset_sel;

    localparam lc3b_offset_sel offset_sel_9  = 1'b0;
    localparam lc3b_offset_sel offset_sel_11 = 1'b1;

    typedef logic [1:0] lc3b_wb_sel;

    localparam lc3b_wb_sel wb_sel_alu    = 2'd0;
    localparam lc3b_wb_sel wb_sel_mdr    = 2'd1;
    localparam lc3b_wb_sel wb_sel_pc     = 2'd2; // link value, old pc + 2
    localparam lc3b_wb_sel wb_sel_target = 2'd3;

    localparam lc3b_word reset_pc = 16'h0000;
    localparam lc3b_reg  r7       = 3'd7;

endpackage : lc3b_types
